/* rtl/mips_isa_pkg.sv */
// mips instruction set encodings, field positions and field types
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [25:0] jidx_t;      // j/jal word index

    // lsb of each instruction field
    localparam int op_lsb = 26;
    localparam int rs_lsb = 21;
    localparam int rt_lsb = 16;
    localparam int rd_lsb = 11;
    localparam int sa_lsb = 6;

    localparam opcode_t op_special = 6'b000000;
    localparam opcode_t op_regimm  = 6'b000001;
    localparam opcode_t op_j       = 6'b000010;
    localparam opcode_t op_jal     = 6'b000011;
    localparam opcode_t op_beq     = 6'b000100;
    localparam opcode_t op_bne     = 6'b000101;
    localparam opcode_t op_blez    = 6'b000110;
    localparam opcode_t op_bgtz    = 6'b000111;
    localparam opcode_t op_addi    = 6'b001000;
    localparam opcode_t op_addiu   = 6'b001001;
    localparam opcode_t op_slti    = 6'b001010;
    localparam opcode_t op_sltiu   = 6'b001011;
    localparam opcode_t op_andi    = 6'b001100;
    localparam opcode_t op_ori     = 6'b001101;
    localparam opcode_t op_xori    = 6'b001110;
    localparam opcode_t op_lui     = 6'b001111;
    localparam opcode_t op_lw      = 6'b100011;
    localparam opcode_t op_sw      = 6'b101011;

    localparam funct_t fn_sll  = 6'b000000;
    localparam funct_t fn_srl  = 6'b000010;
    localparam funct_t fn_sra  = 6'b000011;
    localparam funct_t fn_jr   = 6'b001000;
    localparam funct_t fn_jalr = 6'b001001;
    localparam funct_t fn_add  = 6'b100000;
    localparam funct_t fn_addu = 6'b100001;
    localparam funct_t fn_sub  = 6'b100010;
    localparam funct_t fn_subu = 6'b100011;
    localparam funct_t fn_and  = 6'b100100;
    localparam funct_t fn_or   = 6'b100101;
    localparam funct_t fn_xor  = 6'b100110;
    localparam funct_t fn_slt  = 6'b101010;

    localparam reg_addr_t regimm_bltz   = 5'b00000;  // rt field of regimm group
    localparam reg_addr_t regimm_bgezal = 5'b10001;

    localparam reg_addr_t link_reg = 5'd31;
    localparam word_t     pc_step  = 32'd4;

endpackage

`default_nettype wire

/* rtl/decode_pkg.sv */
// decode stage control types, operand selectors and forwarding source record
`default_nettype none

package decode_pkg;

    typedef logic [5:0] alu_op_t;

    localparam alu_op_t alu_nop     = 6'd0;
    localparam alu_op_t alu_add     = 6'd1;
    localparam alu_op_t alu_sub     = 6'd2;
    localparam alu_op_t alu_and     = 6'd3;
    localparam alu_op_t alu_or      = 6'd4;
    localparam alu_op_t alu_xor     = 6'd5;
    localparam alu_op_t alu_sll     = 6'd6;
    localparam alu_op_t alu_srl     = 6'd7;
    localparam alu_op_t alu_sra     = 6'd8;
    localparam alu_op_t alu_slt     = 6'd9;
    localparam alu_op_t alu_sltu    = 6'd10;
    localparam alu_op_t alu_lui     = 6'd11;
    localparam alu_op_t alu_lw      = 6'd12;
    localparam alu_op_t alu_sw      = 6'd13;
    localparam alu_op_t alu_beq     = 6'd14;
    localparam alu_op_t alu_bne     = 6'd15;
    localparam alu_op_t alu_blez    = 6'd16;
    localparam alu_op_t alu_bgtz    = 6'd17;
    localparam alu_op_t alu_bltz    = 6'd18;
    localparam alu_op_t alu_bgezal  = 6'd19;
    localparam alu_op_t alu_j       = 6'd20;
    localparam alu_op_t alu_jal     = 6'd21;
    localparam alu_op_t alu_jr      = 6'd22;
    localparam alu_op_t alu_jalr    = 6'd23;
    localparam alu_op_t alu_unknown = 6'd63;

    typedef logic [2:0] op1_sel_t;

    localparam op1_sel_t op1_none = 3'd0;
    localparam op1_sel_t op1_rs   = 3'd1;
    localparam op1_sel_t op1_sa   = 3'd2;  // shift amount
    localparam op1_sel_t op1_lui  = 3'd3;
    localparam op1_sel_t op1_pc   = 3'd4;

    typedef logic [2:0] op2_sel_t;

    localparam op2_sel_t op2_none = 3'd0;
    localparam op2_sel_t op2_rt   = 3'd1;
    localparam op2_sel_t op2_ims  = 3'd2;  // sign extended imm
    localparam op2_sel_t op2_imz  = 3'd3;  // zero extended imm
    localparam op2_sel_t op2_four = 3'd4;

    typedef logic [3:0] byte_mask_t;

    localparam byte_mask_t mask_none = 4'b0000;
    localparam byte_mask_t mask_word = 4'b1111;

    typedef struct packed {
        alu_op_t                 alu_op;
        op1_sel_t                op1_sel;
        op2_sel_t                op2_sel;
        logic                    mem_wr;
        logic                    mem_rd;
        byte_mask_t              w_mask;
        byte_mask_t              r_mask;
        logic                    reg_wr;
        mips_isa_pkg::reg_addr_t reg_dst;
    } exe_ctrl_t;

    // bubble seen by execute
    localparam exe_ctrl_t ctrl_idle = '{
        alu_op:  alu_nop,
        op1_sel: op1_none,
        op2_sel: op2_none,
        mem_wr:  1'b0,
        mem_rd:  1'b0,
        w_mask:  mask_none,
        r_mask:  mask_none,
        reg_wr:  1'b0,
        reg_dst: '0
    };

    typedef struct packed {
        logic                    wr;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } bypass_t;

endpackage

`default_nettype wire

/* rtl/if_id_reg.sv */
// fetch to decode pipeline register with instruction valid flag
`timescale 1ns/10ps
`default_nettype none

module if_id_reg (
    input  logic                clk,
    input  logic                rst,
    input  mips_isa_pkg::word_t pc,
    input  mips_isa_pkg::word_t inst,
    output mips_isa_pkg::word_t id_pc,
    output mips_isa_pkg::word_t id_inst,
    output logic                id_valid
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_pc    <= '0;
            id_inst  <= '0;
            id_valid <= 1'b0;
        end else begin
            id_pc    <= pc;
            id_inst  <= inst;
            id_valid <= 1'b1;  // first capture opens the stage
        end
    end

    // nothing may look valid in the cycle after a reset edge
    assert property (@(posedge clk) rst |=> !id_valid)
        else $error("id_valid raised during reset");

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
// instruction decoder producing execute controls and the destination register
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  mips_isa_pkg::word_t   id_inst,
    input  logic                  id_valid,
    output decode_pkg::exe_ctrl_t ctrl
);

    import mips_isa_pkg::*;
    import decode_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    sa;
    exe_ctrl_t dec;

    assign opcode = id_inst[op_lsb +: $bits(opcode_t)];
    assign funct  = id_inst[$bits(funct_t)-1:0];
    assign rs     = id_inst[rs_lsb +: $bits(reg_addr_t)];
    assign rt     = id_inst[rt_lsb +: $bits(reg_addr_t)];
    assign rd     = id_inst[rd_lsb +: $bits(reg_addr_t)];
    assign sa     = id_inst[sa_lsb +: $bits(shamt_t)];

    always_comb begin
        // i-type defaults, overridden per group
        dec         = ctrl_idle;
        dec.alu_op  = alu_unknown;
        dec.op1_sel = op1_rs;
        dec.op2_sel = op2_ims;
        dec.reg_wr  = 1'b1;
        dec.reg_dst = rt;
        case (opcode)
            op_special: begin
                dec.op2_sel = op2_rt;
                dec.reg_dst = rd;
                case (funct)
                    fn_add, fn_addu: if (sa == '0) dec.alu_op = alu_add;
                    fn_sub, fn_subu: if (sa == '0) dec.alu_op = alu_sub;
                    fn_and:          if (sa == '0) dec.alu_op = alu_and;
                    fn_or:           if (sa == '0) dec.alu_op = alu_or;
                    fn_xor:          if (sa == '0) dec.alu_op = alu_xor;
                    fn_slt:          if (sa == '0) dec.alu_op = alu_slt;
                    fn_sll:          if (rs == '0) dec.alu_op = alu_sll;
                    fn_srl:          if (rs == '0) dec.alu_op = alu_srl;
                    fn_sra:          if (rs == '0) dec.alu_op = alu_sra;
                    fn_jr:           if (rt == '0 && rd == '0 && sa == '0) dec.alu_op = alu_jr;
                    fn_jalr:         if (rt == '0 && sa == '0) dec.alu_op = alu_jalr;
                    default: ;
                endcase
                if (funct == fn_sll || funct == fn_srl || funct == fn_sra) begin
                    dec.op1_sel = op1_sa;
                end
                if (funct == fn_jalr) begin
                    dec.op1_sel = op1_pc;  // link value pc + 4
                    dec.op2_sel = op2_four;
                end
                if (funct == fn_jr) begin
                    dec.op1_sel = op1_none;
                    dec.op2_sel = op2_none;
                    dec.reg_wr  = 1'b0;
                end
            end
            op_addi, op_addiu: dec.alu_op = alu_add;
            op_slti:           dec.alu_op = alu_slt;
            op_sltiu:          dec.alu_op = alu_sltu;
            op_andi: begin
                dec.alu_op  = alu_and;
                dec.op2_sel = op2_imz;
            end
            op_ori: begin
                dec.alu_op  = alu_or;
                dec.op2_sel = op2_imz;
            end
            op_xori: begin
                dec.alu_op  = alu_xor;
                dec.op2_sel = op2_imz;
            end
            op_lui: begin
                if (rs == '0) dec.alu_op = alu_lui;
                dec.op1_sel = op1_lui;
                dec.op2_sel = op2_none;
            end
            op_lw: begin
                dec.alu_op = alu_lw;
                dec.mem_rd = 1'b1;
                dec.r_mask = mask_word;
            end
            op_sw: begin
                dec.alu_op = alu_sw;
                dec.mem_wr = 1'b1;
                dec.w_mask = mask_word;
                dec.reg_wr = 1'b0;
            end
            op_beq, op_bne, op_blez, op_bgtz, op_j: begin
                case (opcode)
                    op_beq:  dec.alu_op = alu_beq;
                    op_bne:  dec.alu_op = alu_bne;
                    op_blez: if (rt == '0) dec.alu_op = alu_blez;
                    op_bgtz: if (rt == '0) dec.alu_op = alu_bgtz;
                    default: dec.alu_op = alu_j;
                endcase
                dec.op1_sel = op1_none;
                dec.op2_sel = op2_none;
                dec.reg_wr  = 1'b0;
            end
            op_regimm: begin
                dec.op1_sel = op1_none;
                dec.op2_sel = op2_none;
                dec.reg_wr  = 1'b0;
                if (rt == regimm_bltz) dec.alu_op = alu_bltz;
                if (rt == regimm_bgezal) begin
                    dec.alu_op  = alu_bgezal;
                    dec.op1_sel = op1_pc;
                    dec.op2_sel = op2_four;
                    dec.reg_wr  = 1'b1;
                    dec.reg_dst = link_reg;
                end
            end
            op_jal: begin
                dec.alu_op  = alu_jal;
                dec.op1_sel = op1_pc;
                dec.op2_sel = op2_four;
                dec.reg_dst = link_reg;
            end
            default: ;
        endcase
        if (dec.alu_op == alu_unknown) begin
            dec        = ctrl_idle;  // no write, no memory access
            dec.alu_op = alu_unknown;
        end
    end

    assign ctrl = id_valid ? dec : ctrl_idle;

    assert final (!(ctrl.mem_wr && ctrl.mem_rd))
        else $error("load and store strobes both set");

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
// priority forwarding of pending later-stage writes for one register read port
`timescale 1ns/10ps
`default_nettype none

module operand_bypass #(
    parameter int n_bypass = 3
) (
    input  mips_isa_pkg::reg_addr_t            src_addr,
    input  mips_isa_pkg::word_t                rf_data,
    input  decode_pkg::bypass_t [n_bypass-1:0] bypass,
    output mips_isa_pkg::word_t                val
);

    // walk from the oldest stage so the youngest match lands last
    always_comb begin
        val = rf_data;
        for (int i = n_bypass - 1; i >= 0; i--) begin
            if (bypass[i].wr && bypass[i].addr == src_addr) begin
                val = bypass[i].data;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/operand_select.sv */
// execute operand muxes with immediate extension and store data
`timescale 1ns/10ps
`default_nettype none

module operand_select (
    input  decode_pkg::exe_ctrl_t ctrl,
    input  mips_isa_pkg::word_t   id_inst,
    input  mips_isa_pkg::word_t   id_pc,
    input  mips_isa_pkg::word_t   rs_val,
    input  mips_isa_pkg::word_t   rt_val,
    output mips_isa_pkg::word_t   op_a,
    output mips_isa_pkg::word_t   op_b,
    output mips_isa_pkg::word_t   store_data
);

    import mips_isa_pkg::*;
    import decode_pkg::*;

    imm16_t imm;
    shamt_t sa;

    assign imm = id_inst[$bits(imm16_t)-1:0];
    assign sa  = id_inst[sa_lsb +: $bits(shamt_t)];

    always_comb begin
        case (ctrl.op1_sel)
            op1_rs:  op_a = rs_val;
            op1_sa:  op_a = word_t'(sa);
            op1_lui: op_a = {imm, 16'h0000};  // imm into upper half
            op1_pc:  op_a = id_pc;
            default: op_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            op2_rt:   op_b = rt_val;
            op2_ims:  op_b = {{16{imm[15]}}, imm};
            op2_imz:  op_b = {16'h0000, imm};
            op2_four: op_b = pc_step;  // link adds to pc
            default:  op_b = '0;
        endcase
    end

    assign store_data = rt_val;

endmodule

`default_nettype wire

/* rtl/branch_unit.sv */
// branch condition evaluation and jump and branch target generation
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  decode_pkg::alu_op_t alu_op,
    input  mips_isa_pkg::word_t id_inst,
    input  mips_isa_pkg::word_t id_pc,
    input  mips_isa_pkg::word_t rs_val,
    input  mips_isa_pkg::word_t rt_val,
    output logic                jump_en,
    output mips_isa_pkg::word_t jump_addr
);

    import mips_isa_pkg::*;
    import decode_pkg::*;

    word_t  pc_plus_4;
    word_t  br_target;
    word_t  j_target;
    imm16_t offset;
    jidx_t  index;
    logic   rs_neg;
    logic   rs_zero;

    assign offset    = id_inst[$bits(imm16_t)-1:0];
    assign index     = id_inst[$bits(jidx_t)-1:0];
    assign pc_plus_4 = id_pc + pc_step;
    assign br_target = pc_plus_4 + {{14{offset[15]}}, offset, 2'b00};
    assign j_target  = {pc_plus_4[31:28], index, 2'b00};  // stays in the 256 MB region
    assign rs_neg    = rs_val[31];
    assign rs_zero   = (rs_val == '0);

    always_comb begin
        case (alu_op)
            alu_beq:    jump_en = (rs_val == rt_val);
            alu_bne:    jump_en = (rs_val != rt_val);
            alu_blez:   jump_en = rs_neg || rs_zero;
            alu_bgtz:   jump_en = !rs_neg && !rs_zero;
            alu_bltz:   jump_en = rs_neg;
            alu_bgezal: jump_en = !rs_neg;
            alu_j, alu_jal, alu_jr, alu_jalr: jump_en = 1'b1;
            default:    jump_en = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_beq, alu_bne, alu_blez, alu_bgtz, alu_bltz, alu_bgezal: jump_addr = br_target;
            alu_j, alu_jal:   jump_addr = j_target;
            alu_jr, alu_jalr: jump_addr = rs_val;
            default:          jump_addr = '0;
        endcase
    end

    assert final (!jump_en || jump_addr[1:0] == 2'b00)
        else $error("jump target 0x%08h not word aligned", jump_addr);

endmodule

`default_nettype wire

/* rtl/idu_top.sv */
// instruction decode stage with operand forwarding and branch resolution
`timescale 1ns/10ps
`default_nettype none

module idu_top #(
    parameter int n_bypass = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  mips_isa_pkg::word_t                pc,
    input  mips_isa_pkg::word_t                inst,
    input  mips_isa_pkg::word_t                rs_data,
    input  mips_isa_pkg::word_t                rt_data,
    input  decode_pkg::bypass_t [n_bypass-1:0] bypass,  // 0 execute, 1 memory, 2 writeback
    output mips_isa_pkg::reg_addr_t            rs_addr,
    output mips_isa_pkg::reg_addr_t            rt_addr,
    output decode_pkg::exe_ctrl_t              ctrl,
    output mips_isa_pkg::word_t                op_a,
    output mips_isa_pkg::word_t                op_b,
    output mips_isa_pkg::word_t                store_data,
    output logic                               jump_en,
    output mips_isa_pkg::word_t                jump_addr
);

    import mips_isa_pkg::*;

    word_t id_pc;
    word_t id_inst;
    logic  id_valid;
    word_t rs_val;
    word_t rt_val;

    assign rs_addr = id_inst[rs_lsb +: $bits(reg_addr_t)];
    assign rt_addr = id_inst[rt_lsb +: $bits(reg_addr_t)];

    if_id_reg u_if_id_reg (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .inst     (inst),
        .id_pc    (id_pc),
        .id_inst  (id_inst),
        .id_valid (id_valid)
    );

    inst_decoder u_inst_decoder (
        .id_inst  (id_inst),
        .id_valid (id_valid),
        .ctrl     (ctrl)
    );

    operand_bypass #(.n_bypass(n_bypass)) u_rs_bypass (
        .src_addr (rs_addr),
        .rf_data  (rs_data),
        .bypass   (bypass),
        .val      (rs_val)
    );

    operand_bypass #(.n_bypass(n_bypass)) u_rt_bypass (
        .src_addr (rt_addr),
        .rf_data  (rt_data),
        .bypass   (bypass),
        .val      (rt_val)
    );

    operand_select u_operand_select (
        .ctrl       (ctrl),
        .id_inst    (id_inst),
        .id_pc      (id_pc),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_data (store_data)
    );

    branch_unit u_branch_unit (
        .alu_op    (ctrl.alu_op),
        .id_inst   (id_inst),
        .id_pc     (id_pc),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .jump_en   (jump_en),
        .jump_addr (jump_addr)
    );

endmodule

`default_nettype wire

/* tests/decode_vectors.svh */
// decode stage stimulus and expected-result table with forwarding scenarios
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

    // four forwarding scenarios, index 0 is execute and has priority
    function automatic bypass_vec_t bypass_set(input logic [1:0] sel);
        bypass_vec_t b;
        b = '0;
        case (sel)
            2'd1: begin  // r1 hit in execute and memory, r2 in writeback
                b[0] = {1'b1, 5'd1, 32'hAAAA0000};
                b[1] = {1'b1, 5'd1, 32'hBBBB0000};
                b[2] = {1'b1, 5'd2, 32'hCCCC0000};
            end
            2'd2: begin  // execute not writing, memory other reg
                b[0] = {1'b0, 5'd1, 32'hAAAA0000};
                b[1] = {1'b1, 5'd3, 32'hBBBB0000};
                b[2] = {1'b1, 5'd1, 32'hCCCC0000};
            end
            2'd3: begin
                b[0] = {1'b0, 5'd2, 32'hAAAA0000};
                b[1] = {1'b1, 5'd2, 32'hBBBB1111};
                b[2] = {1'b1, 5'd2, 32'hCCCC2222};
            end
            default: ;
        endcase
        return b;
    endfunction

    // line 1: pc, inst, rs_data, rt_data, bypass set, random rt data
    // line 2: alu_op, {reg_wr, mem_wr, mem_rd}, reg_dst, op_a, op_b, store_data,
    // jump_en, jump_addr
    task automatic load_vectors();
        add_vector(32'h00400000, 32'h00221820, 32'h00000011, 32'h00000022, 2'd0, 1'b0,
            alu_add, 3'b100, 5'd3, 32'h11, 32'h22, 32'h22, 1'b0, 32'h0);
        add_vector(32'h00400004, 32'h00A62022, 32'h00000100, 32'h00000001, 2'd0, 1'b0,
            alu_sub, 3'b100, 5'd4, 32'h100, 32'h1, 32'h1, 1'b0, 32'h0);
        add_vector(32'h00400008, 32'h01093824, 32'hF0F0F0F0, 32'hFF00FF00, 2'd0, 1'b0,
            alu_and, 3'b100, 5'd7, 32'hF0F0F0F0, 32'hFF00FF00, 32'hFF00FF00, 1'b0, 32'h0);
        add_vector(32'h0040000C, 32'h0043082A, 32'hFFFFFFFF, 32'h00000001, 2'd0, 1'b0,
            alu_slt, 3'b100, 5'd1, 32'hFFFFFFFF, 32'h1, 32'h1, 1'b0, 32'h0);
        add_vector(32'h00400010, 32'h00031140, 32'h00000000, 32'h0000000F, 2'd0, 1'b0,
            alu_sll, 3'b100, 5'd2, 32'h5, 32'hF, 32'hF, 1'b0, 32'h0);
        add_vector(32'h00400014, 32'h000527C3, 32'h00000000, 32'h80000000, 2'd0, 1'b0,
            alu_sra, 3'b100, 5'd4, 32'h1F, 32'h80000000, 32'h80000000, 1'b0, 32'h0);
        add_vector(32'h00400018, 32'h2128FFFC, 32'h00000100, 32'h00000000, 2'd0, 1'b1,
            alu_add, 3'b100, 5'd8, 32'h100, 32'hFFFFFFFC, 32'h0, 1'b0, 32'h0);
        add_vector(32'h0040001C, 32'h316A8001, 32'hFFFF0000, 32'h00000000, 2'd0, 1'b1,
            alu_and, 3'b100, 5'd10, 32'hFFFF0000, 32'h00008001, 32'h0, 1'b0, 32'h0);
        add_vector(32'h00400020, 32'h39ACF0F0, 32'h12345678, 32'h00000000, 2'd0, 1'b1,
            alu_xor, 3'b100, 5'd12, 32'h12345678, 32'h0000F0F0, 32'h0, 1'b0, 32'h0);
        add_vector(32'h00400024, 32'h2DEE8000, 32'h7FFFFFFF, 32'h00000000, 2'd0, 1'b1,
            alu_sltu, 3'b100, 5'd14, 32'h7FFFFFFF, 32'hFFFF8000, 32'h0, 1'b0, 32'h0);
        add_vector(32'h00400028, 32'h3C101234, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_lui, 3'b100, 5'd16, 32'h12340000, 32'h0, 32'h0, 1'b0, 32'h0);
        add_vector(32'h0040002C, 32'h8E51FFF8, 32'h00001000, 32'h00000000, 2'd0, 1'b1,
            alu_lw, 3'b101, 5'd17, 32'h1000, 32'hFFFFFFF8, 32'h0, 1'b0, 32'h0);
        add_vector(32'h00400030, 32'hAE93000C, 32'h00002000, 32'hCAFEF00D, 2'd0, 1'b0,
            alu_sw, 3'b010, 5'd0, 32'h2000, 32'hC, 32'hCAFEF00D, 1'b0, 32'h0);
        add_vector(32'h00400034, 32'h00221820, 32'h00000011, 32'h00000022, 2'd1, 1'b0,
            alu_add, 3'b100, 5'd3, 32'hAAAA0000, 32'hCCCC0000, 32'hCCCC0000, 1'b0, 32'h0);
        add_vector(32'h00400038, 32'h00221820, 32'h00000011, 32'h00000022, 2'd2, 1'b0,
            alu_add, 3'b100, 5'd3, 32'hCCCC0000, 32'h22, 32'h22, 1'b0, 32'h0);
        add_vector(32'h0040003C, 32'h00221820, 32'h00000011, 32'h00000022, 2'd3, 1'b0,
            alu_add, 3'b100, 5'd3, 32'h11, 32'hBBBB1111, 32'hBBBB1111, 1'b0, 32'h0);
        add_vector(32'h00400100, 32'h10220004, 32'h00000055, 32'h00000055, 2'd0, 1'b0,
            alu_beq, 3'b000, 5'd0, 32'h0, 32'h0, 32'h55, 1'b1, 32'h00400114);
        add_vector(32'h00400100, 32'h10220004, 32'h00000055, 32'h00000056, 2'd0, 1'b0,
            alu_beq, 3'b000, 5'd0, 32'h0, 32'h0, 32'h56, 1'b0, 32'h00400114);
        add_vector(32'h00400100, 32'h1422FFFE, 32'h00000001, 32'h00000002, 2'd0, 1'b0,
            alu_bne, 3'b000, 5'd0, 32'h0, 32'h0, 32'h2, 1'b1, 32'h004000FC);
        add_vector(32'h00400100, 32'h1422FFFE, 32'h00000007, 32'h00000007, 2'd0, 1'b0,
            alu_bne, 3'b000, 5'd0, 32'h0, 32'h0, 32'h7, 1'b0, 32'h004000FC);
        add_vector(32'h00400100, 32'h18600008, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_blez, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h00400124);
        add_vector(32'h00400100, 32'h18600008, 32'h80000000, 32'h00000000, 2'd0, 1'b1,
            alu_blez, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h00400124);
        add_vector(32'h00400100, 32'h18600008, 32'h00000001, 32'h00000000, 2'd0, 1'b1,
            alu_blez, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h00400124);
        add_vector(32'h00400100, 32'h1C600008, 32'h00000001, 32'h00000000, 2'd0, 1'b1,
            alu_bgtz, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h00400124);
        add_vector(32'h00400100, 32'h1C600008, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_bgtz, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h00400124);
        add_vector(32'h00400100, 32'h1C600008, 32'h80000000, 32'h00000000, 2'd0, 1'b1,
            alu_bgtz, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h00400124);
        add_vector(32'h00400100, 32'h0480FFFF, 32'hFFFFFFFF, 32'h00000000, 2'd0, 1'b1,
            alu_bltz, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h00400100);
        add_vector(32'h00400100, 32'h0480FFFF, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_bltz, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h00400100);
        add_vector(32'h00400100, 32'h04B10100, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_bgezal, 3'b100, 5'd31, 32'h00400100, 32'h4, 32'h0, 1'b1, 32'h00400504);
        add_vector(32'h00400100, 32'h04B10100, 32'h80000000, 32'h00000000, 2'd0, 1'b1,
            alu_bgezal, 3'b100, 5'd31, 32'h00400100, 32'h4, 32'h0, 1'b0, 32'h00400504);
        add_vector(32'h2FFFFFFC, 32'h08100040, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_j, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h30400100);
        add_vector(32'h2FFFFFFC, 32'h0C100040, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_jal, 3'b100, 5'd31, 32'h2FFFFFFC, 32'h4, 32'h0, 1'b1, 32'h30400100);
        add_vector(32'h00400200, 32'h00C00008, 32'h00401000, 32'h00000000, 2'd0, 1'b1,
            alu_jr, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h00401000);
        add_vector(32'h00400200, 32'h00E0F809, 32'h00402000, 32'h00000000, 2'd0, 1'b1,
            alu_jalr, 3'b100, 5'd31, 32'h00400200, 32'h4, 32'h0, 1'b1, 32'h00402000);
        add_vector(32'h00400300, 32'hFC000000, 32'h00000000, 32'h00000000, 2'd0, 1'b1,
            alu_unknown, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0);
        add_vector(32'h00400304, 32'h00220018, 32'h00000011, 32'h00000000, 2'd0, 1'b1,
            alu_unknown, 3'b000, 5'd0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0);
    endtask

`endif

/* tests/tb_idu.sv */
// table driven testbench for the decode stage with reset, forwarding and branch cases
`timescale 1ns/10ps
`default_nettype none

module tb_idu;

    import mips_isa_pkg::*;
    import decode_pkg::*;

    localparam int n_bypass     = 3;
    localparam int clk_half     = 20;  // 40 ns period
    localparam int reset_cycles = 8;

    typedef bypass_t [n_bypass-1:0] bypass_vec_t;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
        word_t      rs_data;
        word_t      rt_data;
        logic [1:0] byp_set;
        logic       rand_rt;  // random rt data that store_data follows
        alu_op_t    alu_op;
        logic       reg_wr;
        reg_addr_t  reg_dst;
        logic       mem_wr;
        logic       mem_rd;
        word_t      op_a;
        word_t      op_b;
        word_t      store_data;
        logic       jump_en;
        word_t      jump_addr;
    } vector_t;

    logic        clk = 1'b0;
    logic        rst;
    word_t       pc;
    word_t       inst;
    word_t       rs_data;
    word_t       rt_data;
    bypass_vec_t bypass;
    reg_addr_t   rs_addr;
    reg_addr_t   rt_addr;
    exe_ctrl_t   ctrl;
    word_t       op_a;
    word_t       op_b;
    word_t       store_data;
    logic        jump_en;
    word_t       jump_addr;

    vector_t vectors[$];
    integer  seed = 58;
    int      errors = 0;
    int      checks = 0;
    int      cycle_count = 0;
    int      cycle_limit = 0;

    idu_top #(.n_bypass(n_bypass)) u_idu_top (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .inst       (inst),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .bypass     (bypass),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .ctrl       (ctrl),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_data (store_data),
        .jump_en    (jump_en),
        .jump_addr  (jump_addr)
    );

    always #clk_half clk = ~clk;

    task automatic add_vector(
        input word_t      vpc,
        input word_t      vinst,
        input word_t      vrs,
        input word_t      vrt,
        input logic [1:0] vbyp,
        input logic       vrand,
        input alu_op_t    valu,
        input logic [2:0] vflags,  // reg_wr, mem_wr, mem_rd
        input reg_addr_t  vdst,
        input word_t      va,
        input word_t      vb,
        input word_t      vsd,
        input logic       vjen,
        input word_t      vjaddr
    );
        vector_t v;
        v = {vpc, vinst, vrs, vrt, vbyp, vrand, valu, vflags[2], vdst, vflags[1],
             vflags[0], va, vb, vsd, vjen, vjaddr};
        vectors.push_back(v);
    endtask

    `include "decode_vectors.svh"

    task automatic compare_value(input string what, input word_t actual, input word_t expected);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                         $time, what, actual, expected);
            end
    endtask

    // bubble has no alu work, memory access, write or jump
    task automatic check_idle(input string when);
        compare_value({when, " alu_op"}, word_t'(ctrl.alu_op), word_t'(alu_nop));
        compare_value({when, " reg_wr"}, word_t'(ctrl.reg_wr), 32'h0);
        compare_value({when, " mem_wr"}, word_t'(ctrl.mem_wr), 32'h0);
        compare_value({when, " mem_rd"}, word_t'(ctrl.mem_rd), 32'h0);
        compare_value({when, " jump_en"}, word_t'(jump_en), 32'h0);
    endtask

    task automatic check_row(input int idx, input vector_t v);
        string tag;
        tag = $sformatf("row %0d", idx);
        compare_value({tag, " rs_addr"}, word_t'(rs_addr), word_t'(v.inst[25:21]));
        compare_value({tag, " rt_addr"}, word_t'(rt_addr), word_t'(v.inst[20:16]));
        compare_value({tag, " alu_op"}, word_t'(ctrl.alu_op), word_t'(v.alu_op));
        compare_value({tag, " reg_wr"}, word_t'(ctrl.reg_wr), word_t'(v.reg_wr));
        if (v.reg_wr) begin
            compare_value({tag, " reg_dst"}, word_t'(ctrl.reg_dst), word_t'(v.reg_dst));
        end
        compare_value({tag, " mem_wr"}, word_t'(ctrl.mem_wr), word_t'(v.mem_wr));
        compare_value({tag, " mem_rd"}, word_t'(ctrl.mem_rd), word_t'(v.mem_rd));
        compare_value({tag, " w_mask"}, word_t'(ctrl.w_mask), word_t'({4{v.mem_wr}}));
        compare_value({tag, " r_mask"}, word_t'(ctrl.r_mask), word_t'({4{v.mem_rd}}));
        compare_value({tag, " op_a"}, op_a, v.op_a);
        compare_value({tag, " op_b"}, op_b, v.op_b);
        compare_value({tag, " store_data"}, store_data, v.store_data);
        compare_value({tag, " jump_en"}, word_t'(jump_en), word_t'(v.jump_en));
        compare_value({tag, " jump_addr"}, jump_addr, v.jump_addr);
    endtask

    initial begin
        vector_t v;
        rst     = 1'b1;
        pc      = 32'h2FFFFFFC;
        inst    = 32'h08100040;  // jump that must stay silent until captured
        rs_data = 32'h00001234;
        rt_data = 32'h00005678;
        bypass  = '0;
        load_vectors();
        cycle_limit = 2 * vectors.size() + reset_cycles + 20;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_idle("reset");
        end
        rst = 1'b0;
        #(clk_half / 2);
        check_idle("after reset");
        for (int i = 0; i < vectors.size(); i++) begin
            v = vectors[i];
            if (v.rand_rt) begin
                v.rt_data    = word_t'($random(seed));
                v.store_data = v.rt_data;
            end
            @(negedge clk);
            pc      = v.pc;
            inst    = v.inst;
            rs_data = v.rs_data;
            rt_data = v.rt_data;
            bypass  = bypass_set(v.byp_set);
            @(negedge clk);
            check_row(i, v);
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+tests
rtl/mips_isa_pkg.sv
rtl/decode_pkg.sv
rtl/if_id_reg.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/operand_select.sv
rtl/branch_unit.sv
rtl/idu_top.sv
tests/tb_idu.sv

/* Bender.yml */
package:
  name: idu

sources:
  - files:
      - rtl/mips_isa_pkg.sv
      - rtl/decode_pkg.sv
      - rtl/if_id_reg.sv
      - rtl/inst_decoder.sv
      - rtl/operand_bypass.sv
      - rtl/operand_select.sv
      - rtl/branch_unit.sv
      - rtl/idu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_idu.sv
